//--- rtl/sdr_reset_chain.sv
`timescale 1ns/1ps

module sdr_reset_chain (
  input  logic                              core_clk_i,
  input  logic                              arst_n_i,
  input  logic                              reset_east_i,
  output logic [sdr_row_pkg::NUM_TILES-1:0] reset_tap_o,
  output logic                              reset_west_o
);

  import sdr_row_pkg::*;

  // stage x belongs to tile x, so the east end is the top bit.
  logic [NUM_TILES-1:0] stage_r;

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stage_r <= '1;
    end else begin
      stage_r <= {reset_east_i, stage_r[NUM_TILES-1:1]}; // one hop west per cycle.
    end
  end

  assign reset_tap_o  = stage_r;
  assign reset_west_o = stage_r[0];

endmodule

//--- rtl/sdr_row_pkg.sv
package sdr_row_pkg;

  // row geometry.
  localparam int NUM_TILES  = 4;
  localparam int TILE_IDX_W = 2;

  // forward link payload.
  localparam int PKT_W = 16;

  // receive FIFO and credit loop.
  localparam int LG_FIFO_DEPTH   = 3;
  localparam int FIFO_DEPTH      = 1 << LG_FIFO_DEPTH;
  localparam int LG_CREDIT_DECIM = 1;
  localparam int CREDIT_DECIM    = 1 << LG_CREDIT_DECIM; // credits carried by one token.
  localparam int CREDIT_W        = LG_FIFO_DEPTH + 1;

  // tag packet layout after the start bit is opcode, tile index, value.
  localparam int TAG_OP_W  = 2;
  localparam int TAG_PKT_W = TAG_OP_W + TILE_IDX_W + 1;
  localparam int TAG_CNT_W = $clog2(TAG_PKT_W);

  typedef enum logic [TAG_OP_W-1:0] {
    TAG_NOP          = 2'd0,
    TAG_CORE_RESET   = 2'd1,
    TAG_LINK_DISABLE = 2'd2,
    TAG_DISABLE_ALL  = 2'd3
  } tag_op_e;

  typedef enum logic [1:0] {
    TAG_IDLE  = 2'd0,
    TAG_SHIFT = 2'd1,
    TAG_APPLY = 2'd2
  } tag_state_e;

endpackage

//--- rtl/sdr_row_top.sv
`timescale 1ns/1ps

module sdr_row_top (
  input  logic                                                     core_clk_i,
  input  logic                                                     arst_n_i,
  input  logic                                                     tag_data_i,
  output logic                                                     core_reset_e_o,
  output logic                                                     core_reset_w_o,
  output logic [sdr_row_pkg::NUM_TILES-1:0]                        core_reset_tile_o,

  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        core_v_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0][sdr_row_pkg::PKT_W-1:0] core_data_i,
  output logic [sdr_row_pkg::NUM_TILES-1:0]                        core_ready_o,

  output logic [sdr_row_pkg::NUM_TILES-1:0]                        io_v_o,
  output logic [sdr_row_pkg::NUM_TILES-1:0][sdr_row_pkg::PKT_W-1:0] io_data_o,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        io_token_i,

  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        io_v_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0][sdr_row_pkg::PKT_W-1:0] io_data_i,
  output logic [sdr_row_pkg::NUM_TILES-1:0]                        io_token_o,

  output logic [sdr_row_pkg::NUM_TILES-1:0]                        core_v_o,
  output logic [sdr_row_pkg::NUM_TILES-1:0][sdr_row_pkg::PKT_W-1:0] core_data_o,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        core_yumi_i
);

  import sdr_row_pkg::*;

  logic [NUM_TILES-1:0] link_disable;

  sdr_tag_ctrl tag_ctrl (
    .core_clk_i     (core_clk_i),
    .arst_n_i       (arst_n_i),
    .tag_data_i     (tag_data_i),
    .core_reset_o   (core_reset_e_o),
    .link_disable_o (link_disable)
  );

  // the east end sees the control register directly.
  sdr_reset_chain reset_chain (
    .core_clk_i   (core_clk_i),
    .arst_n_i     (arst_n_i),
    .reset_east_i (core_reset_e_o),
    .reset_tap_o  (core_reset_tile_o),
    .reset_west_o (core_reset_w_o)
  );

  for (genvar x = 0; x < NUM_TILES; x++) begin : g_tile
    sdr_tx_lane tx_lane (
      .core_clk_i   (core_clk_i),
      .arst_n_i     (arst_n_i),
      .core_reset_i (core_reset_tile_o[x]),
      .disable_i    (link_disable[x]),
      .core_v_i     (core_v_i[x]),
      .core_data_i  (core_data_i[x]),
      .core_ready_o (core_ready_o[x]),
      .io_v_o       (io_v_o[x]),
      .io_data_o    (io_data_o[x]),
      .io_token_i   (io_token_i[x])
    );

    sdr_rx_lane rx_lane (
      .core_clk_i   (core_clk_i),
      .arst_n_i     (arst_n_i),
      .core_reset_i (core_reset_tile_o[x]),
      .disable_i    (link_disable[x]),
      .io_v_i       (io_v_i[x]),
      .io_data_i    (io_data_i[x]),
      .io_token_o   (io_token_o[x]),
      .core_v_o     (core_v_o[x]),
      .core_data_o  (core_data_o[x]),
      .core_yumi_i  (core_yumi_i[x])
    );
  end

endmodule

//--- rtl/sdr_rx_lane.sv
`timescale 1ns/1ps

module sdr_rx_lane (
  input  logic                          core_clk_i,
  input  logic                          arst_n_i,
  input  logic                          core_reset_i,
  input  logic                          disable_i,
  input  logic                          io_v_i,
  input  logic [sdr_row_pkg::PKT_W-1:0] io_data_i,
  output logic                          io_token_o,
  output logic                          core_v_o,
  output logic [sdr_row_pkg::PKT_W-1:0] core_data_o,
  input  logic                          core_yumi_i
);

  import sdr_row_pkg::*;

  logic [PKT_W-1:0]           mem_r [FIFO_DEPTH];
  logic [LG_FIFO_DEPTH-1:0]   wr_ptr_r;
  logic [LG_FIFO_DEPTH-1:0]   rd_ptr_r;
  logic [CREDIT_W-1:0]        count_r;
  logic [LG_CREDIT_DECIM-1:0] pop_cnt_r;
  logic                       wr;
  logic                       pop;
  logic                       full;
  logic                       empty;

  assign wr    = io_v_i && !disable_i && !core_reset_i;
  assign empty = (count_r == '0);
  assign full  = (count_r == CREDIT_W'(FIFO_DEPTH));

  assign core_v_o    = !empty && !disable_i && !core_reset_i;
  assign core_data_o = mem_r[rd_ptr_r];
  assign pop         = core_yumi_i && core_v_o;

  always_ff @(posedge core_clk_i) begin
    if (wr) begin
      mem_r[wr_ptr_r] <= io_data_i;
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      count_r    <= '0;
      pop_cnt_r  <= '0;
      io_token_o <= 1'b0;
    end else if (core_reset_i) begin
      wr_ptr_r   <= '0; // flush whatever was queued.
      rd_ptr_r   <= '0;
      count_r    <= '0;
      pop_cnt_r  <= '0;
      io_token_o <= 1'b0;
    end else begin
      if (wr) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r  <= rd_ptr_r + 1'b1;
        pop_cnt_r <= pop_cnt_r + 1'b1;
      end
      count_r <= count_r + CREDIT_W'(wr) - CREDIT_W'(pop);
      // the pop that completes a batch returns one token a cycle later.
      io_token_o <= pop && (pop_cnt_r == '1);
    end
  end

  // the sender's credits cover every free slot, so a write never finds the FIFO full.
  a_no_overflow: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    wr |-> !full)
    else $error("rx lane wrote into a full FIFO");

  // a pop needs a stored entry between the pointers.
  a_no_underflow: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    pop |-> (rd_ptr_r != wr_ptr_r) || full)
    else $error("rx lane popped an empty FIFO");

endmodule

//--- rtl/sdr_tag_ctrl.sv
`timescale 1ns/1ps

module sdr_tag_ctrl (
  input  logic                              core_clk_i,
  input  logic                              arst_n_i,
  input  logic                              tag_data_i,
  output logic                              core_reset_o,
  output logic [sdr_row_pkg::NUM_TILES-1:0] link_disable_o
);

  import sdr_row_pkg::*;

  tag_state_e            state_r;
  tag_state_e            state_n;
  logic [TAG_PKT_W-1:0]  shift_r;
  logic [TAG_CNT_W-1:0]  cnt_r;
  logic                  core_reset_r;
  logic [NUM_TILES-1:0]  disable_r;

  tag_op_e               op;
  logic [TILE_IDX_W-1:0] idx;
  logic                  val;

  // field decode of the shifted packet.
  assign op  = tag_op_e'(shift_r[TAG_PKT_W-1 -: TAG_OP_W]);
  assign idx = shift_r[1 +: TILE_IDX_W];
  assign val = shift_r[0];

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      TAG_IDLE: begin
        if (tag_data_i) begin // a one while idle is the start bit.
          state_n = TAG_SHIFT;
        end
      end
      TAG_SHIFT: begin
        if (cnt_r == TAG_CNT_W'(TAG_PKT_W - 1)) begin
          state_n = TAG_APPLY;
        end
      end
      TAG_APPLY: begin
        state_n = TAG_IDLE;
      end
      default: begin
        state_n = TAG_IDLE;
      end
    endcase
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= TAG_IDLE;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == TAG_SHIFT) begin
        cnt_r <= cnt_r + 1'b1;
      end else begin
        cnt_r <= '0;
      end
    end
  end

  // MSB arrives first.
  always_ff @(posedge core_clk_i) begin
    if (state_r == TAG_SHIFT) begin
      shift_r <= {shift_r[TAG_PKT_W-2:0], tag_data_i};
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      core_reset_r <= 1'b1; // the core comes up held in reset.
      disable_r    <= '0;
    end else if (state_r == TAG_APPLY) begin
      unique case (op)
        TAG_CORE_RESET:   core_reset_r   <= val;
        TAG_LINK_DISABLE: disable_r[idx] <= val;
        TAG_DISABLE_ALL:  disable_r      <= {NUM_TILES{val}};
        default: begin
        end
      endcase
    end
  end

  assign core_reset_o   = core_reset_r;
  assign link_disable_o = disable_r;

  a_state_legal: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    state_r inside {TAG_IDLE, TAG_SHIFT, TAG_APPLY})
    else $error("tag FSM holds an illegal state encoding");

endmodule

//--- rtl/sdr_tx_lane.sv
`timescale 1ns/1ps

module sdr_tx_lane (
  input  logic                          core_clk_i,
  input  logic                          arst_n_i,
  input  logic                          core_reset_i,
  input  logic                          disable_i,
  input  logic                          core_v_i,
  input  logic [sdr_row_pkg::PKT_W-1:0] core_data_i,
  output logic                          core_ready_o,
  output logic                          io_v_o,
  output logic [sdr_row_pkg::PKT_W-1:0] io_data_o,
  input  logic                          io_token_i
);

  import sdr_row_pkg::*;

  logic [CREDIT_W-1:0] credit_r;
  logic [CREDIT_W-1:0] credit_add;
  logic                send;

  assign core_ready_o = (credit_r != '0) && !disable_i && !core_reset_i;
  assign send         = core_v_i && core_ready_o;

  // each token stands for a batch of consumed packets.
  assign credit_add = io_token_i ? CREDIT_W'(CREDIT_DECIM) : '0;

  always_ff @(posedge core_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      io_v_o   <= 1'b0;
      credit_r <= CREDIT_W'(FIFO_DEPTH);
    end else begin
      io_v_o <= send;
      if (core_reset_i) begin
        credit_r <= CREDIT_W'(FIFO_DEPTH); // the far FIFO is flushed by the same reset.
      end else begin
        credit_r <= credit_r - CREDIT_W'(send) + credit_add;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (send) begin
      io_data_o <= core_data_i;
    end
  end

  // tokens only come back for packets this lane has sent.
  a_credit_bound: assert property (@(posedge core_clk_i) disable iff (!arst_n_i)
    credit_r <= CREDIT_W'(FIFO_DEPTH))
    else $error("tx credit count exceeds the receive FIFO depth");

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the row testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sdr_row_tb --Mdir "$BUILD_DIR" -o sdr_row_sim \
  -f sdr_row_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BUILD_DIR/sdr_row_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0

//--- sdr_row_top.f
rtl/sdr_row_pkg.sv
rtl/sdr_tag_ctrl.sv
rtl/sdr_reset_chain.sv
rtl/sdr_tx_lane.sv
rtl/sdr_rx_lane.sv
rtl/sdr_row_top.sv
verif/sdr_row_checker.sv
verif/sdr_row_tb.sv

//--- verif/sdr_row_checker.sv
`timescale 1ns/1ps

module sdr_row_checker (
  input  logic                                                     core_clk_i,
  input  logic                                                     arst_n_i,
  input  logic                                                     reset_e_i,
  input  logic                                                     reset_w_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        reset_tap_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        tx_v_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0][sdr_row_pkg::PKT_W-1:0] tx_data_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        tx_ready_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        link_v_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0][sdr_row_pkg::PKT_W-1:0] link_data_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        token_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        rx_v_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0][sdr_row_pkg::PKT_W-1:0] rx_data_i,
  input  logic [sdr_row_pkg::NUM_TILES-1:0]                        rx_yumi_i,
  output int                                                       err_count_o
);

  import sdr_row_pkg::*;

  logic [PKT_W-1:0]     exp_q [NUM_TILES][$];
  int                   accepted [NUM_TILES];
  int                   pops [NUM_TILES];
  int                   tokens [NUM_TILES];
  int                   cyc = 0;
  int                   e_cyc = 0;
  logic                 e_q = 1'b1;
  logic                 w_q = 1'b1;
  logic [NUM_TILES-1:0] tap_q = '1;
  logic [NUM_TILES-1:0] acc_q = '0;
  logic [PKT_W-1:0]     acc_data_q [NUM_TILES];
  int                   test_errs = 0;
  int                   errors = 0;
  int                   tests_run = 0;
  int                   tests_failed = 0;

  assign err_count_o = errors;

  task automatic count_error();
    test_errs++;
    errors++;
  endtask

  always @(posedge core_clk_i) begin : watch
    logic [PKT_W-1:0] head;
    cyc++;
    if (arst_n_i) begin
      if (reset_e_i != e_q) begin
        e_cyc = cyc;
      end
      if (reset_w_i != w_q && cyc - e_cyc != NUM_TILES) begin
        $display("west core reset moved %0d cycles after the east end, expected %0d",
                 cyc - e_cyc, NUM_TILES);
        count_error();
      end
      for (int x = 0; x < NUM_TILES; x++) begin
        if (reset_tap_i[x] != tap_q[x] && cyc - e_cyc != NUM_TILES - x) begin
          $display("tile %0d reset tap moved %0d cycles after the east end, expected %0d",
                   x, cyc - e_cyc, NUM_TILES - x);
          count_error();
        end
        if (reset_tap_i[x]) begin
          exp_q[x].delete(); // a held core reset empties the receive FIFO.
          pops[x]   = 0;
          tokens[x] = 0;
        end
        if (token_i[x]) begin
          tokens[x]++;
        end
        if (rx_v_i[x] && rx_yumi_i[x]) begin
          pops[x]++;
          if (exp_q[x].size() == 0) begin
            $display("tile %0d delivered a packet that was never sent", x);
            count_error();
          end else begin
            head = exp_q[x].pop_front();
            if (rx_data_i[x] !== head) begin
              $display("ERROR core_data_o[%0d] got 0x%h expected 0x%h", x, rx_data_i[x], head);
              count_error();
            end
          end
        end
        // the link carries each accepted packet in the very next cycle.
        if (link_v_i[x] !== acc_q[x]) begin
          $display("ERROR io_v_o[%0d] got 0x%h expected 0x%h", x, link_v_i[x], acc_q[x]);
          count_error();
        end else if (acc_q[x] && link_data_i[x] !== acc_data_q[x]) begin
          $display("ERROR io_data_o[%0d] got 0x%h expected 0x%h", x, link_data_i[x],
                   acc_data_q[x]);
          count_error();
        end
        acc_q[x]      = tx_v_i[x] && tx_ready_i[x];
        acc_data_q[x] = tx_data_i[x];
        if (tx_v_i[x] && tx_ready_i[x]) begin
          exp_q[x].push_back(tx_data_i[x]);
          accepted[x]++;
        end
      end
    end
    e_q   = reset_e_i;
    w_q   = reset_w_i;
    tap_q = reset_tap_i;
  end

  task automatic start_test();
    test_errs = 0;
    for (int x = 0; x < NUM_TILES; x++) begin
      accepted[x] = 0;
    end
  endtask

  // a disabled tile must not take a single packet.
  task automatic check_accepted(input logic [NUM_TILES-1:0] mask,
                                input logic [NUM_TILES-1:0] dead, input int exp_n);
    int want;
    for (int x = 0; x < NUM_TILES; x++) begin
      want = dead[x] ? 0 : exp_n;
      if (mask[x] && accepted[x] != want) begin
        $display("tile %0d accepted %0d packets, expected %0d", x, accepted[x], want);
        count_error();
      end
    end
  endtask

  task automatic check_rx_idle();
    if (rx_v_i !== '0) begin
      $display("ERROR core_v_o got 0x%h expected 0x%h", rx_v_i, {NUM_TILES{1'b0}});
      count_error();
    end
  endtask

  task automatic finish_test(input string name, input logic hold);
    for (int x = 0; x < NUM_TILES; x++) begin
      if (tokens[x] != (pops[x] >> LG_CREDIT_DECIM)) begin
        $display("ERROR io_token_o[%0d] pulses 0x%h expected 0x%h", x, tokens[x],
                 pops[x] >> LG_CREDIT_DECIM);
        count_error();
      end
      if (!hold && exp_q[x].size() != 0) begin
        $display("tile %0d never delivered %0d sent packets", x, exp_q[x].size());
        count_error();
      end
    end
    tests_run++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, test_errs);
    end
  endtask

  task automatic report();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
  endtask

endmodule

//--- verif/sdr_row_tb.sv
`timescale 1ns/1ps

module sdr_row_tb;

  import sdr_row_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int NUM_TESTS    = 9;
  localparam int STALL_CYCLES = 16; // this many quiet cycles means the senders are stalled.
  localparam int LIMIT_CYCLES = NUM_TESTS * 200 + 100;

  typedef struct {
    string                 name;
    logic                  tag_en;
    tag_op_e               tag_op;
    logic [TILE_IDX_W-1:0] tag_idx;
    logic                  tag_val;
    logic [NUM_TILES-1:0]  mask;
    int                    count;
    logic                  withhold;  // tokens cut and yumi low until the senders stall.
    logic                  hold_fifo; // packets stay queued in the receive FIFOs.
    int                    exp_acc;
    logic [NUM_TILES-1:0]  dead;
  } test_t;

  logic                            core_clk;
  logic                            arst_n;
  logic                            tag_data;
  logic                            core_reset_e;
  logic                            core_reset_w;
  logic [NUM_TILES-1:0]            core_reset_tile;
  logic [NUM_TILES-1:0]            core_v;
  logic [NUM_TILES-1:0][PKT_W-1:0] core_data;
  logic [NUM_TILES-1:0]            core_ready;
  logic [NUM_TILES-1:0]            link_v;
  logic [NUM_TILES-1:0][PKT_W-1:0] link_data;
  logic [NUM_TILES-1:0]            token_out;
  logic [NUM_TILES-1:0]            token_in;
  logic                            token_en;
  logic [NUM_TILES-1:0]            rx_v;
  logic [NUM_TILES-1:0][PKT_W-1:0] rx_data;
  logic [NUM_TILES-1:0]            yumi;
  int                              err_count;

  test_t            tests [NUM_TESTS];
  logic [31:0]      lfsr;
  logic [PKT_W-1:0] next_word [NUM_TILES];
  int               sent [NUM_TILES];

  assign token_in = token_en ? token_out : '0;

  initial core_clk = 1'b0;
  always #(CLK_PERIOD / 2) core_clk = ~core_clk;

  // each tile's forward link is looped straight back into its own receiver.
  sdr_row_top dut_i (
    .core_clk_i (core_clk), .arst_n_i (arst_n), .tag_data_i (tag_data),
    .core_reset_e_o (core_reset_e), .core_reset_w_o (core_reset_w),
    .core_reset_tile_o (core_reset_tile),
    .core_v_i (core_v), .core_data_i (core_data), .core_ready_o (core_ready),
    .io_v_o (link_v), .io_data_o (link_data), .io_token_i (token_in),
    .io_v_i (link_v), .io_data_i (link_data), .io_token_o (token_out),
    .core_v_o (rx_v), .core_data_o (rx_data), .core_yumi_i (yumi)
  );

  sdr_row_checker row_checker (
    .core_clk_i (core_clk), .arst_n_i (arst_n), .reset_e_i (core_reset_e),
    .reset_w_i (core_reset_w), .reset_tap_i (core_reset_tile),
    .tx_v_i (core_v), .tx_data_i (core_data), .tx_ready_i (core_ready),
    .link_v_i (link_v), .link_data_i (link_data),
    .token_i (token_out), .rx_v_i (rx_v), .rx_data_i (rx_data), .rx_yumi_i (yumi),
    .err_count_o (err_count)
  );

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [PKT_W-1:0] random_word();
    logic [PKT_W-1:0] w;
    for (int i = 0; i < PKT_W; i++) begin
      lfsr = next_lfsr(lfsr);
      w[i] = lfsr[0];
    end
    return w;
  endfunction

  task automatic fill_table();
    // name, tag, op, index, value, mask, count, withhold, hold, accepted, dead.
    tests[0] = '{"reset_release", 1'b1, TAG_CORE_RESET, 2'd0, 1'b0, 4'h0, 0, 1'b0, 1'b0, 0, 4'h0};
    tests[1] = '{"loopback", 1'b0, TAG_NOP, 2'd0, 1'b0, 4'hf, 20, 1'b0, 1'b0, 20, 4'h0};
    tests[2] = '{"back_pressure", 1'b0, TAG_NOP, 2'd0, 1'b0, 4'hf, 12, 1'b1, 1'b0, 8, 4'h0};
    tests[3] = '{"token_decim", 1'b0, TAG_NOP, 2'd0, 1'b0, 4'hf, 7, 1'b0, 1'b0, 7, 4'h0};
    tests[4] = '{"link_disable", 1'b1, TAG_LINK_DISABLE, 2'd2, 1'b1, 4'hf, 6, 1'b0, 1'b0, 6, 4'h4};
    tests[5] = '{"disable_clear", 1'b1, TAG_DISABLE_ALL, 2'd0, 1'b0, 4'hf, 6, 1'b0, 1'b0, 6, 4'h0};
    tests[6] = '{"fill_hold", 1'b0, TAG_NOP, 2'd0, 1'b0, 4'hf, 4, 1'b0, 1'b1, 4, 4'h0};
    tests[7] = '{"reset_assert", 1'b1, TAG_CORE_RESET, 2'd0, 1'b1, 4'h0, 0, 1'b0, 1'b0, 0, 4'h0};
    tests[8] = '{"reset_flush", 1'b1, TAG_CORE_RESET, 2'd0, 1'b0, 4'hf, 12, 1'b1, 1'b0, 8, 4'h0};
  endtask

  // start bit, then opcode, index and value with the MSB first.
  task automatic send_tag(input tag_op_e op, input logic [TILE_IDX_W-1:0] idx, input logic val);
    logic [TAG_PKT_W-1:0] bits;
    bits = {op, idx, val};
    @(negedge core_clk);
    tag_data = 1'b1;
    for (int i = TAG_PKT_W - 1; i >= 0; i--) begin
      @(negedge core_clk);
      tag_data = bits[i];
    end
    @(negedge core_clk);
    tag_data = 1'b0; // the control applies the packet in this cycle.
    @(negedge core_clk);
  endtask

  task automatic wait_reset_west(input logic val);
    do begin
      @(posedge core_clk);
    end while (core_reset_w != val);
    @(negedge core_clk);
  endtask

  task automatic run_packets(input logic [NUM_TILES-1:0] mask, input int count);
    logic [NUM_TILES-1:0] busy;
    int                   idle;
    idle = 0;
    for (int x = 0; x < NUM_TILES; x++) begin
      busy[x] = mask[x] && (sent[x] < count);
    end
    while (busy != '0 && idle < STALL_CYCLES) begin
      @(negedge core_clk);
      core_v = busy;
      for (int x = 0; x < NUM_TILES; x++) begin
        core_data[x] = next_word[x];
      end
      @(posedge core_clk);
      idle++;
      for (int x = 0; x < NUM_TILES; x++) begin
        if (busy[x] && core_ready[x]) begin
          idle = 0;
          sent[x]++;
          next_word[x] = random_word();
          busy[x] = (sent[x] < count);
        end
      end
    end
    @(negedge core_clk);
    core_v = '0;
  endtask

  task automatic wait_drained(input logic hold);
    do begin
      @(posedge core_clk);
    end while (link_v != '0 || (!hold && rx_v != '0));
    @(negedge core_clk); // lets the last token pulse be counted.
  endtask

  task automatic run_test(input int t);
    test_t tc;
    tc = tests[t];
    row_checker.start_test();
    for (int x = 0; x < NUM_TILES; x++) begin
      sent[x] = 0;
    end
    if (tc.tag_en) begin
      send_tag(tc.tag_op, tc.tag_idx, tc.tag_val);
      if (tc.tag_op == TAG_CORE_RESET) begin
        wait_reset_west(tc.tag_val);
        if (!tc.tag_val) begin
          row_checker.check_rx_idle(); // a released core starts with empty receive FIFOs.
        end
      end
    end
    yumi     = {NUM_TILES{!(tc.withhold || tc.hold_fifo)}};
    token_en = !tc.withhold;
    run_packets(tc.mask, tc.count);
    if (tc.withhold) begin
      row_checker.check_accepted(tc.mask, tc.dead, tc.exp_acc);
      yumi     = '1;
      token_en = 1'b1;
      run_packets(tc.mask, tc.count);
    end
    wait_drained(tc.hold_fifo);
    row_checker.check_accepted(tc.mask, tc.dead, tc.withhold ? tc.count : tc.exp_acc);
    row_checker.finish_test(tc.name, tc.hold_fifo);
  endtask

  initial begin
    lfsr      = 32'hac82_d828;
    arst_n    = 1'b0;
    tag_data  = 1'b0;
    core_v    = '0;
    core_data = '0;
    yumi      = '0;
    token_en  = 1'b1;
    for (int x = 0; x < NUM_TILES; x++) begin
      next_word[x] = random_word();
    end
    fill_table();
    repeat (2) @(negedge core_clk);
    arst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    row_checker.report();
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not complete within %0d cycles", LIMIT_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule
